// File: Makefile
# Verilator build and run of the cache to dram bridge testbench

VERILATOR ?= verilator
TOP       ?= cache_to_dram_tb
FILELIST  ?= cache_to_dram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cache_to_dram.f
src/cache_dram_pkg.sv
src/dram_fifo.sv
src/dma_req_decode.sv
src/dma_write_execute.sv
src/dma_read_result.sv
src/cache_to_dram.sv
test/cache_to_dram_checker.sv
test/cache_to_dram_tb.sv

// File: src/cache_dram_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes, packet and beat structs, channel address helper
// shared by the cache to dram bridge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cache_dram_pkg;

  localparam int NUM_CACHE      = 2;
  localparam int CACHE_ID_W     = 1;
  localparam int ADDR_W         = 12;  // cache byte address
  localparam int BANK_ADDR_W    = 10;  // byte address bits used inside a bank
  localparam int WORD_W         = 32;
  localparam int BLOCK_WORDS    = 4;
  localparam int DRAM_W         = 64;
  localparam int CH_ADDR_W      = 12;  // dram channel byte address

  localparam int NUM_REQ        = BLOCK_WORDS * WORD_W / DRAM_W;  // requests per block
  localparam int WORDS_PER_BEAT = DRAM_W / WORD_W;
  localparam int BEAT_OFS_W     = $clog2(DRAM_W / 8);
  localparam int REQ_CNT_W      = $clog2(NUM_REQ);
  localparam int WORD_SEL_W     = $clog2(WORDS_PER_BEAT);

  localparam int RD_BUF_DEPTH   = 4;  // also the number of read credits
  localparam int REQ_BUF_DEPTH  = 4;
  localparam int CREDIT_W       = $clog2(RD_BUF_DEPTH + 1);

  typedef logic [CACHE_ID_W-1:0] cache_id_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [DRAM_W-1:0]     beat_t;

  // miss or write-back from one cache bank
  typedef struct packed {
    logic              write_not_read;
    logic [ADDR_W-1:0] addr;
  } dma_pkt_s;

  typedef struct packed {
    logic                 write_not_read;
    logic [CH_ADDR_W-1:0] ch_addr;
  } dram_req_s;

  // read data coming back from the channel, tagged with its address
  typedef struct packed {
    logic [CH_ADDR_W-1:0] ch_addr;
    beat_t                data;
  } read_beat_s;

  // bank in the top bit, then unused bits, block address, beat count, byte offset
  function automatic logic [CH_ADDR_W-1:0] make_ch_addr(
    input cache_id_t             bank,
    input logic [ADDR_W-1:0]     addr,
    input logic [REQ_CNT_W-1:0]  beat
  );
    make_ch_addr = {bank,
                    {(CH_ADDR_W - CACHE_ID_W - BANK_ADDR_W){1'b0}},
                    addr[BANK_ADDR_W-1:BEAT_OFS_W+REQ_CNT_W],
                    beat,
                    {BEAT_OFS_W{1'b0}}};
  endfunction

endpackage

// File: src/cache_to_dram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the cache banks to test dram bridge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_to_dram
  import cache_dram_pkg::*;
(
  input  logic                 core_clk_i,
  input  logic                 core_reset_i,

  // dma packets from the banks
  input  dma_pkt_s             dma_pkt_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_pkt_v_i,
  output logic [NUM_CACHE-1:0] dma_pkt_yumi_o,

  output word_t                dma_rdata_o [NUM_CACHE],
  output logic [NUM_CACHE-1:0] dma_rdata_v_o,
  input  logic [NUM_CACHE-1:0] dma_rdata_ready_i,

  input  word_t                dma_wdata_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_wdata_v_i,
  output logic [NUM_CACHE-1:0] dma_wdata_yumi_o,

  // dram channel
  output logic                 dram_req_v_o,
  output dram_req_s            dram_req_o,
  input  logic                 dram_req_yumi_i,

  output logic                 dram_wdata_v_o,
  output beat_t                dram_wdata_o,
  input  logic                 dram_wdata_yumi_i,

  input  logic                 dram_rdata_v_i,
  input  read_beat_s           dram_rdata_i
);

  logic      tx_v;
  cache_id_t tx_tag;
  logic      tx_ready;
  logic      credit_return;

  dma_req_decode decode0 (
    .core_clk_i      (core_clk_i),
    .core_reset_i    (core_reset_i),
    .dma_pkt_i       (dma_pkt_i),
    .dma_pkt_v_i     (dma_pkt_v_i),
    .dma_pkt_yumi_o  (dma_pkt_yumi_o),
    .tx_v_o          (tx_v),
    .tx_tag_o        (tx_tag),
    .tx_ready_i      (tx_ready),
    .credit_return_i (credit_return),
    .dram_req_v_o    (dram_req_v_o),
    .dram_req_o      (dram_req_o),
    .dram_req_yumi_i (dram_req_yumi_i)
  );

  dma_write_execute execute0 (
    .core_clk_i        (core_clk_i),
    .core_reset_i      (core_reset_i),
    .tx_v_i            (tx_v),
    .tx_tag_i          (tx_tag),
    .tx_ready_o        (tx_ready),
    .dma_wdata_i       (dma_wdata_i),
    .dma_wdata_v_i     (dma_wdata_v_i),
    .dma_wdata_yumi_o  (dma_wdata_yumi_o),
    .dram_wdata_v_o    (dram_wdata_v_o),
    .dram_wdata_o      (dram_wdata_o),
    .dram_wdata_yumi_i (dram_wdata_yumi_i)
  );

  dma_read_result result0 (
    .core_clk_i        (core_clk_i),
    .core_reset_i      (core_reset_i),
    .dram_rdata_v_i    (dram_rdata_v_i),
    .dram_rdata_i      (dram_rdata_i),
    .dma_rdata_o       (dma_rdata_o),
    .dma_rdata_v_o     (dma_rdata_v_o),
    .dma_rdata_ready_i (dma_rdata_ready_i),
    .credit_return_o   (credit_return)
  );

endmodule

// File: src/dma_read_result.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read return buffer, beat unpacking and routing to the owning bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dma_read_result
  import cache_dram_pkg::*;
(
  input  logic                 core_clk_i,
  input  logic                 core_reset_i,

  input  logic                 dram_rdata_v_i,
  input  read_beat_s           dram_rdata_i,

  output word_t                dma_rdata_o [NUM_CACHE],
  output logic [NUM_CACHE-1:0] dma_rdata_v_o,
  input  logic [NUM_CACHE-1:0] dma_rdata_ready_i,

  output logic                 credit_return_o
);

  read_beat_s             head;
  logic                   head_v;
  cache_id_t              head_bank;
  logic [WORD_SEL_W-1:0]  word_sel_r;   // word of the head beat on show
  word_t                  rd_word;
  logic                   last_word;
  logic                   hs;
  logic                   beat_deq;

  // no back-pressure here, decode keeps the credits so the buffer never overflows
  dram_fifo #(
    .payload_t (read_beat_s),
    .DEPTH     (RD_BUF_DEPTH)
  ) rd_fifo (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (dram_rdata_v_i),
    .data_i       (dram_rdata_i),
    .full_o       (),
    .deq_i        (beat_deq),
    .data_o       (head),
    .valid_o      (head_v)
  );

  assign head_bank = head.ch_addr[CH_ADDR_W-1 -: CACHE_ID_W];
  assign rd_word   = head.data[word_sel_r*WORD_W +: WORD_W];
  assign last_word = (word_sel_r == WORD_SEL_W'(WORDS_PER_BEAT - 1));
  assign hs        = head_v && dma_rdata_ready_i[head_bank];
  assign beat_deq  = hs && last_word;

  // a slot frees once its high word is taken
  assign credit_return_o = beat_deq;

  always_comb begin
    for (int i = 0; i < NUM_CACHE; i++) begin
      dma_rdata_o[i]   = rd_word;                                   // shared data lines
      dma_rdata_v_o[i] = head_v && (head_bank == cache_id_t'(i));   // only the owner sees valid
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      word_sel_r <= '0;
    end else if (hs) begin
      word_sel_r <= last_word ? '0 : word_sel_r + 1'b1;
    end
  end

endmodule

// File: src/dma_req_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round-robin packet arbiter, block splitter and address forming
// read credit counter and the dram request queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dma_req_decode
  import cache_dram_pkg::*;
(
  input  logic                 core_clk_i,
  input  logic                 core_reset_i,

  input  dma_pkt_s             dma_pkt_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_pkt_v_i,
  output logic [NUM_CACHE-1:0] dma_pkt_yumi_o,

  output logic                 tx_v_o,
  output cache_id_t            tx_tag_o,
  input  logic                 tx_ready_i,

  input  logic                 credit_return_i,

  output logic                 dram_req_v_o,
  output dram_req_s            dram_req_o,
  input  logic                 dram_req_yumi_i
);

  cache_id_t             last_r;   // last winner, search starts after it
  logic                  rr_v;
  cache_id_t             rr_tag;
  dma_pkt_s              rr_pkt;

  dma_pkt_s              pkt_r;    // packet being split
  cache_id_t             tag_r;
  dma_pkt_s              cur_pkt;
  cache_id_t             cur_tag;
  logic [REQ_CNT_W-1:0]  count_r;
  logic [REQ_CNT_W-1:0]  count_n;

  logic [CREDIT_W-1:0]   credits_r;
  logic [CREDIT_W-1:0]   credit_take;
  logic                  credit_ok;

  logic                  accept;
  logic                  req_enq;
  logic                  req_full;
  dram_req_s             req_data;

  // first valid bank after the last winner
  always_comb begin
    int idx;
    rr_v   = 1'b0;
    rr_tag = '0;
    for (int i = 1; i <= NUM_CACHE; i++) begin
      idx = (int'(last_r) + i) % NUM_CACHE;
      if (!rr_v && dma_pkt_v_i[idx]) begin
        rr_v   = 1'b1;
        rr_tag = cache_id_t'(idx);
      end
    end
  end

  assign rr_pkt    = dma_pkt_i[rr_tag];
  assign credit_ok = (credits_r >= CREDIT_W'(NUM_REQ));

  always_comb begin
    accept  = 1'b0;
    req_enq = 1'b0;
    tx_v_o  = 1'b0;
    cur_pkt = pkt_r;
    cur_tag = tag_r;
    if (count_r == '0) begin
      cur_pkt = rr_pkt;  // beat 0 goes out straight from the arbiter
      cur_tag = rr_tag;
      if (rr_v && !req_full && (rr_pkt.write_not_read ? tx_ready_i : credit_ok)) begin
        accept  = 1'b1;
        req_enq = 1'b1;
        tx_v_o  = rr_pkt.write_not_read;
      end
    end else if (!req_full && (!pkt_r.write_not_read || tx_ready_i)) begin
      req_enq = 1'b1;
      tx_v_o  = pkt_r.write_not_read;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CACHE; i++) begin
      dma_pkt_yumi_o[i] = accept && (rr_tag == cache_id_t'(i));
    end
  end

  assign count_n     = (count_r == REQ_CNT_W'(NUM_REQ - 1)) ? '0 : count_r + 1'b1;
  assign credit_take = (accept && !rr_pkt.write_not_read) ? CREDIT_W'(NUM_REQ) : '0;
  assign tx_tag_o    = cur_tag;

  assign req_data.write_not_read = cur_pkt.write_not_read;
  assign req_data.ch_addr        = make_ch_addr(cur_tag, cur_pkt.addr, count_r);

  always_ff @(posedge core_clk_i) begin
    if (accept) begin
      pkt_r <= rr_pkt;
      tag_r <= rr_tag;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      last_r    <= '0;
      count_r   <= '0;
      credits_r <= CREDIT_W'(RD_BUF_DEPTH);  // every read slot free
    end else begin
      if (accept) begin
        last_r <= rr_tag;
      end
      if (req_enq) begin
        count_r <= count_n;
      end
      credits_r <= credits_r - credit_take + CREDIT_W'(credit_return_i);
    end
  end

  dram_fifo #(
    .payload_t (dram_req_s),
    .DEPTH     (REQ_BUF_DEPTH)
  ) req_fifo (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (req_enq),
    .data_i       (req_data),
    .full_o       (req_full),
    .deq_i        (dram_req_yumi_i),
    .data_o       (dram_req_o),
    .valid_o      (dram_req_v_o)
  );

endmodule

// File: src/dma_write_execute.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write tag queue and packer of cache words into dram beats
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dma_write_execute
  import cache_dram_pkg::*;
(
  input  logic                 core_clk_i,
  input  logic                 core_reset_i,

  input  logic                 tx_v_i,
  input  cache_id_t            tx_tag_i,
  output logic                 tx_ready_o,

  input  word_t                dma_wdata_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_wdata_v_i,
  output logic [NUM_CACHE-1:0] dma_wdata_yumi_o,

  output logic                 dram_wdata_v_o,
  output beat_t                dram_wdata_o,
  input  logic                 dram_wdata_yumi_i
);

  logic                          tag_full;
  logic                          tag_v;
  cache_id_t                     tag_head;   // bank owning the beat being packed

  word_t [WORDS_PER_BEAT-2:0]    part_r;     // lower words of the beat
  logic [WORD_SEL_W-1:0]         word_sel_r;
  word_t                         sel_word;
  logic                          last_word;
  logic                          take;
  logic                          beat_enq;
  logic                          beat_full;
  beat_t                         beat_data;

  assign tx_ready_o = !tag_full;

  dram_fifo #(
    .payload_t (cache_id_t),
    .DEPTH     (REQ_BUF_DEPTH)
  ) tag_fifo (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (tx_v_i),
    .data_i       (tx_tag_i),
    .full_o       (tag_full),
    .deq_i        (beat_enq),
    .data_o       (tag_head),
    .valid_o      (tag_v)
  );

  assign sel_word  = dma_wdata_i[tag_head];
  assign last_word = (word_sel_r == WORD_SEL_W'(WORDS_PER_BEAT - 1));
  assign take      = tag_v && dma_wdata_v_i[tag_head] && !beat_full;  // stall on full beat queue
  assign beat_enq  = take && last_word;
  assign beat_data = {sel_word, part_r};  // top word arrives last

  always_comb begin
    for (int i = 0; i < NUM_CACHE; i++) begin
      dma_wdata_yumi_o[i] = take && (tag_head == cache_id_t'(i));
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (take && !last_word) begin
      part_r[word_sel_r] <= sel_word;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      word_sel_r <= '0;
    end else if (take) begin
      word_sel_r <= last_word ? '0 : word_sel_r + 1'b1;
    end
  end

  dram_fifo #(
    .payload_t (beat_t),
    .DEPTH     (REQ_BUF_DEPTH)
  ) beat_fifo (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_i),
    .enq_i        (beat_enq),
    .data_i       (beat_data),
    .full_o       (beat_full),
    .deq_i        (dram_wdata_yumi_i),
    .data_o       (dram_wdata_o),
    .valid_o      (dram_wdata_v_o)
  );

endmodule

// File: src/dram_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous circular buffer FIFO of any payload type
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dram_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     core_clk_i,
  input  logic     core_reset_i,

  input  logic     enq_i,
  input  payload_t data_i,
  output logic     full_o,

  input  logic     deq_i,
  output payload_t data_o,
  output logic     valid_o
);

  payload_t                     mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_r;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_r;
  logic [$clog2(DEPTH+1)-1:0]   count_r;
  logic                         do_enq;
  logic                         do_deq;

  assign full_o  = (count_r == ($clog2(DEPTH+1))'(DEPTH));
  assign valid_o = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];

  assign do_enq = enq_i && !full_o;  // writes into a full queue are dropped
  assign do_deq = deq_i && valid_o;

  always_ff @(posedge core_clk_i) begin
    if (do_enq) begin
      mem[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr_r <= (wr_ptr_r == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (do_deq) begin
        rd_ptr_r <= (rd_ptr_r == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      if (do_enq && !do_deq) begin
        count_r <= count_r + 1'b1;
      end else if (do_deq && !do_enq) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

// File: test/cache_to_dram_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bridge checker: port monitor, reference memory
// per-test counts and closing report
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_to_dram_checker
  import cache_dram_pkg::*;
#(
  parameter int SAMPLE_DLY = 15
) (
  input  logic                 core_clk_i,
  input  logic                 core_reset_i,
  input  dma_pkt_s             dma_pkt_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_pkt_v_i,
  input  logic [NUM_CACHE-1:0] dma_pkt_yumi_i,
  input  word_t                dma_rdata_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_rdata_v_i,
  input  logic [NUM_CACHE-1:0] dma_rdata_ready_i,
  input  word_t                dma_wdata_i [NUM_CACHE],
  input  logic [NUM_CACHE-1:0] dma_wdata_v_i,
  input  logic [NUM_CACHE-1:0] dma_wdata_yumi_i,
  input  logic                 dram_req_v_i,
  input  dram_req_s            dram_req_i,
  input  logic                 dram_req_yumi_i,
  input  logic                 dram_wdata_v_i,
  input  beat_t                dram_wdata_i,
  input  logic                 dram_wdata_yumi_i,
  input  logic                 dram_rdata_v_i,
  input  read_beat_s           dram_rdata_i,
  input  logic                 report_i,
  output int                   err_total_o
);

  string       test_name [5] = '{"split_addr", "write_pack", "read_route",
                                 "backpressure", "fair_reset"};
  int          chk_n [5];
  int          err_n [5];

  dram_req_s   exp_req [$];          // requests still due, in accept order
  logic [11:0] exp_wb_addr [$];      // addresses of write beats still due
  word_t       seen_w [NUM_CACHE][$];
  word_t       exp_rd [NUM_CACHE][$];
  beat_t       ref_mem [512];
  beat_t       snap_q [512][$];      // read data as it stood at request time
  logic [NUM_CACHE-1:0] held_v;
  word_t       held_d [NUM_CACHE];
  cache_id_t   last_win;
  logic        seen_in;

  function automatic beat_t initial_beat(input int idx);
    return {32'hc0de0000 | 32'(idx), ~(32'(idx) << 3)};
  endfunction

  function automatic int beat_idx(input logic [11:0] a);
    return int'(a[11:3]);
  endfunction

  // bank on top, block address, beat count, byte offset zero
  function automatic logic [11:0] chan_addr(input int bank, input logic [11:0] addr,
                                            input int beat);
    return {bank[0], 1'b0, addr[9:4], beat[0], 3'b000};
  endfunction

  task automatic check_val(input int t, input logic [63:0] exp, input logic [63:0] act);
    chk_n[t]++;
    if (exp !== act) begin
      err_n[t]++;
      $display("CHECK FAILED %s: expected %h actual %h", test_name[t], exp, act);
    end
  endtask

  task automatic fault(input int t, input string what);
    chk_n[t]++;
    err_n[t]++;
    $display("ERROR %s: %s", test_name[t], what);
  endtask

  initial begin
    for (int i = 0; i < 512; i++) begin
      ref_mem[i] = initial_beat(i);
    end
    held_v   = '0;
    last_win = '0;
    seen_in  = 1'b0;
  end

  task automatic watch_cycle();
    logic [11:0] a;
    beat_t       exp_beat;
    int          bank;
    dram_req_s   er;
    if (!seen_in) begin
      if (dma_pkt_v_i != '0 || dma_wdata_v_i != '0 || dram_rdata_v_i) begin
        seen_in = 1'b1;
      end else begin  // quiet outputs after reset
        check_val(4, 64'd0, 64'({dma_pkt_yumi_i, dma_wdata_yumi_i, dma_rdata_v_i,
                                 dram_req_v_i, dram_wdata_v_i}));
      end
    end
    for (int b = 0; b < NUM_CACHE; b++) begin
      if (dma_pkt_yumi_i[b] && !dma_pkt_v_i[b]) fault(4, "packet yumi without valid");
      if (dma_pkt_yumi_i[b] && dma_pkt_v_i[b]) begin
        if (&dma_pkt_v_i) begin
          check_val(4, 64'((int'(last_win) + 1) % NUM_CACHE), 64'(b));
        end
        last_win = cache_id_t'(b);
        for (int k = 0; k < NUM_REQ; k++) begin
          er.write_not_read = dma_pkt_i[b].write_not_read;
          er.ch_addr        = chan_addr(b, dma_pkt_i[b].addr, k);
          exp_req.push_back(er);
          if (er.write_not_read) exp_wb_addr.push_back(er.ch_addr);
        end
      end
      if (dma_wdata_yumi_i[b] && !dma_wdata_v_i[b]) fault(3, "write word yumi without valid");
      if (dma_wdata_yumi_i[b] && dma_wdata_v_i[b]) seen_w[b].push_back(dma_wdata_i[b]);
    end
    if (dram_wdata_v_i && dram_wdata_yumi_i) begin
      if (exp_wb_addr.size() == 0) begin
        fault(1, "write beat with no write request");
      end else begin
        a    = exp_wb_addr.pop_front();
        bank = int'(a[11]);
        if (seen_w[bank].size() < 2) begin
          fault(1, "write beat sent before both of its words were taken");
        end else begin
          exp_beat[31:0]  = seen_w[bank].pop_front();  // lower address, lower half
          exp_beat[63:32] = seen_w[bank].pop_front();
          check_val(1, exp_beat, dram_wdata_i);
          ref_mem[beat_idx(a)] = exp_beat;
        end
      end
    end
    if (dram_req_v_i && dram_req_yumi_i) begin
      if (exp_req.size() == 0) begin
        fault(0, "dram request with no accepted packet");
      end else begin
        er = exp_req.pop_front();
        check_val(0, 64'(er), 64'(dram_req_i));
        if (!er.write_not_read) begin
          snap_q[beat_idx(er.ch_addr)].push_back(ref_mem[beat_idx(er.ch_addr)]);
        end
      end
    end
    for (int b = 0; b < NUM_CACHE; b++) begin
      if (held_v[b]) begin  // word must stay put while ready was low
        check_val(3, 64'({1'b1, held_d[b]}), 64'({dma_rdata_v_i[b], dma_rdata_i[b]}));
      end
      if (dma_rdata_v_i[b]) begin
        if (exp_rd[b].size() == 0) begin
          fault(2, "read word valid on a bank that has no word due");
        end else if (dma_rdata_ready_i[b]) begin
          check_val(2, 64'(exp_rd[b].pop_front()), 64'(dma_rdata_i[b]));
        end
      end
      held_v[b] = dma_rdata_v_i[b] && !dma_rdata_ready_i[b];
      held_d[b] = dma_rdata_i[b];
    end
    if (dram_rdata_v_i) begin
      a = dram_rdata_i.ch_addr;
      if (snap_q[beat_idx(a)].size() == 0) begin
        fault(2, "read return for an address with no read pending");
      end else begin
        exp_beat = snap_q[beat_idx(a)].pop_front();
        check_val(2, exp_beat, dram_rdata_i.data);
        exp_rd[int'(a[11])].push_back(exp_beat[31:0]);
        exp_rd[int'(a[11])].push_back(exp_beat[63:32]);
      end
    end
  endtask

  always begin
    @(negedge core_clk_i);
    #(SAMPLE_DLY);  // just before the rising edge
    if (!core_reset_i) watch_cycle();
  end

  always @(posedge report_i) begin
    int checks;
    int errs;
    if (exp_req.size() != 0 || exp_wb_addr.size() != 0) begin
      fault(3, "dram requests or write beats never appeared");
    end
    for (int b = 0; b < NUM_CACHE; b++) begin
      if (exp_rd[b].size() != 0 || seen_w[b].size() != 0) begin
        fault(3, "cache words left over at the end");
      end
    end
    for (int i = 0; i < 512; i++) begin
      if (snap_q[i].size() != 0) fault(3, "read requests never returned");
    end
    checks = 0;
    errs   = 0;
    for (int t = 0; t < 5; t++) begin
      $display("test %s: %0d checks, %0d errors", test_name[t], chk_n[t], err_n[t]);
      checks += chk_n[t];
      errs   += err_n[t];
    end
    $display("total: %0d checks, %0d errors", checks, errs);
    err_total_o = errs;
  end

endmodule

// File: test/cache_to_dram_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench: clock, reset, lfsr stimulus
// cache bank models and the dram model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_to_dram_tb;
  import cache_dram_pkg::*;

  localparam int CLK_HALF   = 20;
  localparam int SAMPLE_DLY = 15;
  localparam int NUM_PKT    = 40;
  localparam int MAX_CYCLES = 20000;

  logic                 core_clk;
  logic                 core_reset;
  dma_pkt_s             pkt [NUM_CACHE];
  logic [NUM_CACHE-1:0] pkt_v;
  logic [NUM_CACHE-1:0] pkt_yumi;
  word_t                rdata [NUM_CACHE];
  logic [NUM_CACHE-1:0] rdata_v;
  logic [NUM_CACHE-1:0] rdata_ready;
  word_t                wdata [NUM_CACHE];
  logic [NUM_CACHE-1:0] wdata_v;
  logic [NUM_CACHE-1:0] wdata_yumi;
  logic                 req_v;
  dram_req_s            req;
  logic                 req_yumi;
  logic                 dwd_v;
  beat_t                dwd;
  logic                 dwd_yumi;
  logic                 dret_v;
  read_beat_s           dret;
  logic                 report;
  int                   err_total;

  logic [15:0] lfsr = 16'd57081;
  dma_pkt_s    pkt_q [NUM_CACHE][$];   // packets each bank still has to send
  word_t       word_q [NUM_CACHE][$];
  logic [11:0] wr_addr_q [$];          // write requests waiting for their beat
  logic [11:0] ret_addr [$];
  beat_t       ret_data [$];
  int          ret_dly [$];
  beat_t       mem [512];

  logic [NUM_CACHE-1:0] pkt_hs;
  logic [NUM_CACHE-1:0] wd_hs;
  logic [NUM_CACHE-1:0] rd_hs;
  logic                 req_hs;
  logic                 dwd_hs;
  dram_req_s            req_s;
  beat_t                dwd_s;
  int                   accepted;
  int                   words_due;
  int                   words_got;
  int                   beats_due;
  int                   beats_got;
  int                   cyc;
  logic                 go;
  logic                 finished;

  always #(CLK_HALF) core_clk = ~core_clk;

  cache_to_dram dut0 (
    .core_clk_i (core_clk), .core_reset_i (core_reset),
    .dma_pkt_i (pkt), .dma_pkt_v_i (pkt_v), .dma_pkt_yumi_o (pkt_yumi),
    .dma_rdata_o (rdata), .dma_rdata_v_o (rdata_v), .dma_rdata_ready_i (rdata_ready),
    .dma_wdata_i (wdata), .dma_wdata_v_i (wdata_v), .dma_wdata_yumi_o (wdata_yumi),
    .dram_req_v_o (req_v), .dram_req_o (req), .dram_req_yumi_i (req_yumi),
    .dram_wdata_v_o (dwd_v), .dram_wdata_o (dwd), .dram_wdata_yumi_i (dwd_yumi),
    .dram_rdata_v_i (dret_v), .dram_rdata_i (dret)
  );

  cache_to_dram_checker #(.SAMPLE_DLY (SAMPLE_DLY)) chk0 (
    .core_clk_i (core_clk), .core_reset_i (core_reset),
    .dma_pkt_i (pkt), .dma_pkt_v_i (pkt_v), .dma_pkt_yumi_i (pkt_yumi),
    .dma_rdata_i (rdata), .dma_rdata_v_i (rdata_v), .dma_rdata_ready_i (rdata_ready),
    .dma_wdata_i (wdata), .dma_wdata_v_i (wdata_v), .dma_wdata_yumi_i (wdata_yumi),
    .dram_req_v_i (req_v), .dram_req_i (req), .dram_req_yumi_i (req_yumi),
    .dram_wdata_v_i (dwd_v), .dram_wdata_i (dwd), .dram_wdata_yumi_i (dwd_yumi),
    .dram_rdata_v_i (dret_v), .dram_rdata_i (dret),
    .report_i (report), .err_total_o (err_total)
  );

  // fibonacci lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic beat_t initial_beat(input int idx);
    return {32'hc0de0000 | 32'(idx), ~(32'(idx) << 3)};
  endfunction

  task automatic make_packets();
    dma_pkt_s    p;
    logic [31:0] b;
    logic [31:0] blk;
    logic [31:0] ofs;
    logic [31:0] hi;
    for (int n = 0; n < NUM_PKT; n++) begin
      b   = rand_bits(1);
      p.write_not_read = (rand_bits(1) != 0);
      blk = rand_bits(2);  // four blocks per bank, so blocks come back often
      ofs = rand_bits(4);
      hi  = rand_bits(2);
      p.addr = {hi[1:0], 4'b0000, blk[1:0], ofs[3:0]};
      pkt_q[int'(b)].push_back(p);
    end
  endtask

  task automatic apply_handshakes();
    for (int b = 0; b < NUM_CACHE; b++) begin
      if (pkt_hs[b]) begin
        if (pkt_q[b][0].write_not_read) begin
          for (int k = 0; k < BLOCK_WORDS; k++) word_q[b].push_back(rand_bits(32));
          beats_due += NUM_REQ;
        end else begin
          words_due += BLOCK_WORDS;
        end
        pkt_q[b].delete(0);
        pkt_v[b] = 1'b0;
        accepted++;
      end
      if (wd_hs[b]) begin
        word_q[b].delete(0);
        wdata_v[b] = 1'b0;
      end
      if (rd_hs[b]) words_got++;
    end
    if (dwd_hs) begin
      mem[wr_addr_q[0][11:3]] = dwd_s;
      wr_addr_q.delete(0);
      beats_got++;
    end
    if (req_hs) begin
      if (req_s.write_not_read) begin
        wr_addr_q.push_back(req_s.ch_addr);
      end else begin
        ret_addr.push_back(req_s.ch_addr);
        ret_data.push_back(mem[req_s.ch_addr[11:3]]);  // data as it stands now
        ret_dly.push_back(1 + int'(rand_bits(3)));
        swap_last_returns();
      end
    end
  endtask

  // sometimes swap the two newest returns, never two of one address
  task automatic swap_last_returns();
    int          n;
    logic [11:0] a;
    beat_t       d;
    int          t;
    n = ret_addr.size();
    if (n >= 2 && rand_bits(2) == 0 && ret_addr[n-1] != ret_addr[n-2]) begin
      a = ret_addr[n-1];
      ret_addr[n-1] = ret_addr[n-2];
      ret_addr[n-2] = a;
      d = ret_data[n-1];
      ret_data[n-1] = ret_data[n-2];
      ret_data[n-2] = d;
      t = ret_dly[n-1];
      ret_dly[n-1]  = ret_dly[n-2];
      ret_dly[n-2]  = t;
    end
  endtask

  task automatic drive_inputs();
    int   sel;
    logic older;
    dret_v = 1'b0;
    sel    = -1;
    for (int i = 0; i < ret_dly.size(); i++) ret_dly[i] = ret_dly[i] - 1;
    for (int i = 0; i < ret_addr.size(); i++) begin
      older = 1'b0;
      for (int j = 0; j < i; j++) begin
        if (ret_addr[j] == ret_addr[i]) older = 1'b1;
      end
      if (sel < 0 && ret_dly[i] <= 0 && !older) sel = i;
    end
    if (sel >= 0) begin
      dret_v       = 1'b1;
      dret.ch_addr = ret_addr[sel];
      dret.data    = ret_data[sel];
      ret_addr.delete(sel);
      ret_data.delete(sel);
      ret_dly.delete(sel);
    end
    for (int b = 0; b < NUM_CACHE; b++) begin
      if (go && !pkt_v[b]) pkt_v[b] = (pkt_q[b].size() > 0) && (rand_bits(2) != 0);
      if (pkt_v[b]) pkt[b] = pkt_q[b][0];  // held until yumi
      if (!wdata_v[b]) wdata_v[b] = (word_q[b].size() > 0) && (rand_bits(2) != 0);
      if (wdata_v[b]) wdata[b] = word_q[b][0];
      rdata_ready[b] = go && (rand_bits(2) != 0);
    end
    // reads wait until every earlier write beat is in memory
    req_yumi = req_v && (rand_bits(2) != 0) && (req.write_not_read || wr_addr_q.size() == 0);
    // a beat is taken only once its write request has been
    dwd_yumi = dwd_v && (wr_addr_q.size() != 0) && (rand_bits(1) != 0);
  endtask

  task automatic sample_handshakes();
    pkt_hs = pkt_v & pkt_yumi;
    wd_hs  = wdata_v & wdata_yumi;
    rd_hs  = rdata_v & rdata_ready;
    req_hs = req_v && req_yumi;
    req_s  = req;
    dwd_hs = dwd_v && dwd_yumi;
    dwd_s  = dwd;
  endtask

  initial begin
    core_clk    = 1'b0;
    core_reset  = 1'b1;
    report      = 1'b0;
    pkt_v       = '0;
    wdata_v     = '0;
    rdata_ready = '0;
    req_yumi    = 1'b0;
    dwd_yumi    = 1'b0;
    dret_v      = 1'b0;
    dret        = '0;
    pkt_hs      = '0;
    wd_hs       = '0;
    rd_hs       = '0;
    req_hs      = 1'b0;
    dwd_hs      = 1'b0;
    req_s       = '0;
    dwd_s       = '0;
    go          = 1'b0;
    finished    = 1'b0;
    for (int b = 0; b < NUM_CACHE; b++) begin
      pkt[b]   = '0;
      wdata[b] = '0;
    end
    for (int i = 0; i < 512; i++) mem[i] = initial_beat(i);
    accepted  = 0;
    words_due = 0;
    words_got = 0;
    beats_due = 0;
    beats_got = 0;
    cyc       = 0;
    make_packets();
    repeat (4) @(negedge core_clk);
    core_reset = 1'b0;
    while (!finished && cyc < MAX_CYCLES) begin
      @(negedge core_clk);
      apply_handshakes();
      go = (cyc >= 3);  // a few idle cycles after reset first
      drive_inputs();
      #(SAMPLE_DLY);
      sample_handshakes();
      cyc++;
      finished = (accepted == NUM_PKT) && (words_got == words_due)
                 && (beats_got == beats_due) && (ret_addr.size() == 0)
                 && (wr_addr_q.size() == 0);
    end
    if (!finished) $display("timeout: transfers still open after %0d cycles", cyc);
    report = 1'b1;
    #1;
    if (finished && err_total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
